/* project.f */
src/rv_isa_pkg.sv
src/exe_ctl_pkg.sv
src/ctl_decoder.sv
src/branch_resolve.sv
src/credit_counter.sv
src/exe_stage_reg.sv
src/exe_ctl_top.sv
testbench/exe_ctl_assert.sv
testbench/exe_ctl_checker.sv
testbench/tb_exe_ctl.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_exe_ctl \
    --Mdir obj_dir -o sim_exe_ctl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_exe_ctl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
exit 0

/* testbench/tb_exe_ctl.sv */
`default_nettype none

module tb_exe_ctl;

    import rv_isa_pkg::*;

    localparam int N_ITEMS       = 2000;
    localparam int CLK_PERIOD    = 20;
    localparam int WATCHDOG_TIME = N_ITEMS * 4 * CLK_PERIOD + 50 * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic [31:0] instruction;
    logic [31:0] data_a;
    logic [31:0] data_b;
    logic [31:0] pc_de;
    logic        credit_return;
    logic        in_ready;
    logic        out_valid;
    logic        a_sel_exe;
    logic        b_sel_exe;
    logic [3:0]  imm_sel_exe;
    logic [3:0]  alu_sel_exe;
    logic        br_comp_exe;
    logic        pc_sel_exe;
    logic [31:0] data_a_exe;
    logic [31:0] data_b_exe;
    logic [31:0] pc_exe;
    logic [31:0] instr_exe;
    int          mismatch_count;
    int          other_count;
    int          item_count;
    int          stall_count;
    int          pending;

    logic [31:0] lfsr_state = 32'he7c7;
    logic [31:0] r;
    int          items_sent = 0;
    int          outstanding = 0;
    int          extra_errors = 0;
    logic        accepted_prev = 1'b0;
    logic        credit_prev = 1'b0;

    exe_ctl_top u_exe_ctl_top (.*);

    exe_ctl_checker u_exe_ctl_checker (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // Branches and ALU groups get extra weight
    function automatic logic [6:0] pick_opcode(input logic [3:0] k);
        logic [6:0] opc;
        case (k)
            4'd0:               opc = OPC_LUI;
            4'd1:               opc = OPC_AUIPC;
            4'd2:               opc = OPC_JAL;
            4'd3:               opc = OPC_JALR;
            4'd4, 4'd5, 4'd6:   opc = OPC_BRANCH;
            4'd7:               opc = OPC_LOAD;
            4'd8:               opc = OPC_STORE;
            4'd9, 4'd10:        opc = OPC_OP_IMM;
            4'd11, 4'd12:       opc = OPC_OP;
            4'd13:              opc = 7'b0001111;
            default:            opc = 7'b1111011;
        endcase
        return opc;
    endfunction

    task automatic new_item();
        logic [31:0] bits;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        rand_bits(4, bits);
        opc = pick_opcode(bits[3:0]);
        rand_bits(4, bits);
        f3 = bits[2:0];
        f7 = bits[3] ? F7_ALT : 7'd0;
        rand_bits(15, bits);
        instruction = {f7, bits[14:5], f3, bits[4:0], opc};
        rand_bits(32, bits);
        data_a = bits;
        rand_bits(32, bits);
        data_b = bits;
        rand_bits(2, bits);
        if (bits[1:0] == 2'b00) begin
            data_b = data_a;
        end
        rand_bits(30, bits);
        pc_de = {bits[29:0], 2'b00};
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout, the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        instruction = '0;
        data_a = '0;
        data_b = '0;
        pc_de = '0;
        credit_return = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        while (items_sent < N_ITEMS) begin
            // A refused item stays on the inputs
            if (!(in_valid && !accepted_prev)) begin
                rand_bits(2, r);
                in_valid = (r[1:0] != 2'b00);
                if (in_valid) begin
                    new_item();
                end
            end
            // Slow credit phases build up back-pressure
            rand_bits(2, r);
            if ((items_sent % 500) < 200) begin
                credit_return = (outstanding > 0) && (r[1:0] == 2'b00);
            end else begin
                credit_return = (outstanding > 0) && (r[1:0] != 2'b00);
            end
            accepted_prev = in_valid && in_ready;
            credit_prev = credit_return;
            @(posedge clk);
            #2;
            if (accepted_prev) begin
                items_sent++;
                outstanding++;
            end
            if (credit_prev) begin
                outstanding--;
            end
        end
        in_valid = 1'b0;
        credit_return = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        if (stall_count == 0) begin
            extra_errors++;
            $display("back-pressure never occurred, in_ready was never low with in_valid");
        end
        if (pending != 0) begin
            extra_errors++;
            $display("%0d expected items never came out of the stage", pending);
        end
        if (item_count != items_sent) begin
            extra_errors++;
            $display("%0d items were accepted but %0d were checked", items_sent, item_count);
        end
        $display("items %0d, stalls %0d, mismatches %0d, other errors %0d",
                 item_count, stall_count, mismatch_count, other_count + extra_errors);
        if (mismatch_count == 0 && other_count + extra_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/exe_ctl_checker.sv */
`default_nettype none

module exe_ctl_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic        in_ready,
    input  logic [31:0] instruction,
    input  logic [31:0] data_a,
    input  logic [31:0] data_b,
    input  logic [31:0] pc_de,
    input  logic        credit_return,
    input  logic        out_valid,
    input  logic        a_sel_exe,
    input  logic        b_sel_exe,
    input  logic [3:0]  imm_sel_exe,
    input  logic [3:0]  alu_sel_exe,
    input  logic        br_comp_exe,
    input  logic        pc_sel_exe,
    input  logic [31:0] data_a_exe,
    input  logic [31:0] data_b_exe,
    input  logic [31:0] pc_exe,
    input  logic [31:0] instr_exe,
    output int          mismatch_count,
    output int          other_count,
    output int          item_count,
    output int          stall_count,
    output int          pending
);

    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    typedef struct packed {
        logic [10:0] ctl;
        logic        pc_sel;
        logic [31:0] data_a;
        logic [31:0] data_b;
        logic [31:0] pc;
        logic [31:0] instr;
    } item_t;

    // ALU operation by funct3 before the funct7 variants
    localparam logic [3:0] ALU_BY_F3 [8] = '{
        ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND
    };

    item_t exp_q[$];
    item_t exp_item;
    int    credits;
    logic  prev_accept;
    logic  accept;

    function automatic logic [3:0] model_alu(input logic [2:0] f3, input logic alt,
                                             input logic is_op);
        logic [3:0] op;
        op = ALU_BY_F3[f3];
        if (alt && f3 == F3_SRL_SRA) begin
            op = ALU_SRA;
        end
        if (alt && is_op && f3 == F3_ADD_SUB) begin
            op = ALU_SUB;
        end
        return op;
    endfunction

    // {a_sel, b_sel, imm_sel, alu_sel, br_comp}
    function automatic logic [10:0] model_ctl(input logic [31:0] w);
        logic [10:0] c;
        logic        alt;
        alt = (w[31:25] == F7_ALT);
        case (w[6:0])
            OPC_LUI:    c = {2'b01, IMM_U, ALU_PASS_B, 1'b0};
            OPC_AUIPC:  c = {2'b11, IMM_U, ALU_ADD, 1'b0};
            OPC_JAL:    c = {2'b11, IMM_J, ALU_ADD, 1'b0};
            OPC_JALR:   c = {2'b01, IMM_I, ALU_ADD, 1'b0};
            OPC_BRANCH: c = {2'b00, IMM_B, ALU_ADD, 1'b1};
            OPC_LOAD:   c = {2'b01, IMM_I, ALU_ADD, 1'b0};
            OPC_STORE:  c = {2'b01, IMM_S, ALU_ADD, 1'b0};
            OPC_OP_IMM: c = {2'b01, IMM_I, model_alu(w[14:12], alt, 1'b0), 1'b0};
            OPC_OP:     c = {2'b00, IMM_R, model_alu(w[14:12], alt, 1'b1), 1'b0};
            default:    c = '0;
        endcase
        return c;
    endfunction

    function automatic logic model_pc_sel(input logic [31:0] w, input logic [31:0] a,
                                          input logic [31:0] b);
        logic t;
        case (w[14:12])
            F3_BEQ:  t = (a == b);
            F3_BNE:  t = (a != b);
            F3_BLT:  t = ($signed(a) < $signed(b));
            F3_BGE:  t = ($signed(a) >= $signed(b));
            F3_BLTU: t = (a < b);
            F3_BGEU: t = (a >= b);
            default: t = 1'b0;
        endcase
        if (w[6:0] == OPC_JAL || w[6:0] == OPC_JALR) begin
            t = 1'b1;
        end else if (w[6:0] != OPC_BRANCH) begin
            t = 1'b0;
        end
        return t;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            mismatch_count++;
            $display("mismatch %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            mismatch_count = 0;
            other_count = 0;
            item_count = 0;
            stall_count = 0;
            credits = CREDITS;
            prev_accept = 1'b0;
            exp_q.delete();
            compare_value("reset_state", 32'({1'b0, 1'b1, 12'h000}),
                          32'({out_valid, in_ready, a_sel_exe, b_sel_exe, imm_sel_exe,
                               alu_sel_exe, br_comp_exe, pc_sel_exe}));
        end else begin
            compare_value("out_valid_timing", 32'(prev_accept), 32'(out_valid));
            compare_value("in_ready_credits", 32'(credits != 0), 32'(in_ready));
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("out_valid high at %0t with no item waiting", $time);
                end else begin
                    exp_item = exp_q.pop_front();
                    item_count++;
                    compare_value("decode", 32'(exp_item.ctl),
                                  32'({a_sel_exe, b_sel_exe, imm_sel_exe, alu_sel_exe,
                                       br_comp_exe}));
                    compare_value("pc_sel", 32'(exp_item.pc_sel), 32'(pc_sel_exe));
                    compare_value("data_a", exp_item.data_a, data_a_exe);
                    compare_value("data_b", exp_item.data_b, data_b_exe);
                    compare_value("pc", exp_item.pc, pc_exe);
                    compare_value("instr", exp_item.instr, instr_exe);
                end
            end
            accept = in_valid && in_ready;
            if (accept) begin
                exp_item.ctl = model_ctl(instruction);
                exp_item.pc_sel = model_pc_sel(instruction, data_a, data_b);
                exp_item.data_a = data_a;
                exp_item.data_b = data_b;
                exp_item.pc = pc_de;
                exp_item.instr = instruction;
                exp_q.push_back(exp_item);
            end
            if (in_valid && !in_ready) begin
                stall_count++;
            end
            if (accept && !credit_return) begin
                credits--;
            end else if (!accept && credit_return) begin
                credits++;
            end
            prev_accept = accept;
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* testbench/exe_ctl_assert.sv */
`default_nettype none

module exe_ctl_assert (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_ready,
    input logic credit_return,
    input logic out_valid
);

    // Output item needs a transfer on the edge before
    valid_after_transfer: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid && in_ready))
        else $error("out_valid high without a transfer on the previous edge");

    // Only a transfer can use up a credit
    ready_falls_only_on_transfer: assert property (@(posedge clk) disable iff (rst)
        (in_ready && !in_valid) |=> in_ready)
        else $error("in_ready fell although no item was transferred");

    // Ready stays low until a credit comes back
    ready_waits_for_credit: assert property (@(posedge clk) disable iff (rst)
        (!in_ready && !credit_return) |=> !in_ready)
        else $error("in_ready rose without a returned credit");

endmodule

bind exe_ctl_top exe_ctl_assert u_exe_ctl_assert (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .credit_return (credit_return),
    .out_valid     (out_valid)
);

`default_nettype wire

/* src/exe_ctl_top.sv */
`default_nettype none

module exe_ctl_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  rv_isa_pkg::rv_instr_u       instruction,
    input  logic [rv_isa_pkg::XLEN-1:0] data_a,
    input  logic [rv_isa_pkg::XLEN-1:0] data_b,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_de,
    input  logic                        credit_return,
    output logic                        in_ready,
    output logic                        out_valid,
    output logic                        a_sel_exe,
    output logic                        b_sel_exe,
    output exe_ctl_pkg::imm_sel_e       imm_sel_exe,
    output exe_ctl_pkg::alu_op_e        alu_sel_exe,
    output logic                        br_comp_exe,
    output logic                        pc_sel_exe,
    output logic [rv_isa_pkg::XLEN-1:0] data_a_exe,
    output logic [rv_isa_pkg::XLEN-1:0] data_b_exe,
    output logic [rv_isa_pkg::XLEN-1:0] pc_exe,
    output logic [rv_isa_pkg::XLEN-1:0] instr_exe
);

    logic                  a_sel;
    logic                  b_sel;
    exe_ctl_pkg::imm_sel_e imm_sel;
    exe_ctl_pkg::alu_op_e  alu_sel;
    logic                  br_comp;
    exe_ctl_pkg::pc_rule_e pc_rule;
    logic                  taken;
    logic                  accept;

    // Transfer handshake toward the stage register and the credits
    assign accept = in_valid && in_ready;

    ctl_decoder u_ctl_decoder (
        .instruction (instruction),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .imm_sel     (imm_sel),
        .alu_sel     (alu_sel),
        .br_comp     (br_comp),
        .pc_rule     (pc_rule)
    );

    branch_resolve u_branch_resolve (
        .funct3 (instruction.r.funct3),
        .data_a (data_a),
        .data_b (data_b),
        .taken  (taken)
    );

    credit_counter u_credit_counter (
        .clk           (clk),
        .rst           (rst),
        .accept        (accept),
        .credit_return (credit_return),
        .in_ready      (in_ready)
    );

    exe_stage_reg u_exe_stage_reg (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .imm_sel     (imm_sel),
        .alu_sel     (alu_sel),
        .br_comp     (br_comp),
        .pc_rule     (pc_rule),
        .taken       (taken),
        .data_a      (data_a),
        .data_b      (data_b),
        .pc_de       (pc_de),
        .instruction (instruction),
        .out_valid   (out_valid),
        .a_sel_exe   (a_sel_exe),
        .b_sel_exe   (b_sel_exe),
        .imm_sel_exe (imm_sel_exe),
        .alu_sel_exe (alu_sel_exe),
        .br_comp_exe (br_comp_exe),
        .pc_sel_exe  (pc_sel_exe),
        .data_a_exe  (data_a_exe),
        .data_b_exe  (data_b_exe),
        .pc_exe      (pc_exe),
        .instr_exe   (instr_exe)
    );

endmodule

`default_nettype wire

/* src/exe_stage_reg.sv */
`default_nettype none

module exe_stage_reg (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        accept,
    input  logic                        a_sel,
    input  logic                        b_sel,
    input  exe_ctl_pkg::imm_sel_e       imm_sel,
    input  exe_ctl_pkg::alu_op_e        alu_sel,
    input  logic                        br_comp,
    input  exe_ctl_pkg::pc_rule_e       pc_rule,
    input  logic                        taken,
    input  logic [rv_isa_pkg::XLEN-1:0] data_a,
    input  logic [rv_isa_pkg::XLEN-1:0] data_b,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_de,
    input  rv_isa_pkg::rv_instr_u       instruction,
    output logic                        out_valid,
    output logic                        a_sel_exe,
    output logic                        b_sel_exe,
    output exe_ctl_pkg::imm_sel_e       imm_sel_exe,
    output exe_ctl_pkg::alu_op_e        alu_sel_exe,
    output logic                        br_comp_exe,
    output logic                        pc_sel_exe,
    output logic [rv_isa_pkg::XLEN-1:0] data_a_exe,
    output logic [rv_isa_pkg::XLEN-1:0] data_b_exe,
    output logic [rv_isa_pkg::XLEN-1:0] pc_exe,
    output logic [rv_isa_pkg::XLEN-1:0] instr_exe
);

    import exe_ctl_pkg::*;

    logic pc_sel;

    // Redirect on any jump, or on a branch whose compare holds
    assign pc_sel = (pc_rule == PC_JUMP) || ((pc_rule == PC_COND) && taken);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            a_sel_exe   <= 1'b0;
            b_sel_exe   <= 1'b0;
            imm_sel_exe <= IMM_R;
            alu_sel_exe <= ALU_AND;
            br_comp_exe <= 1'b0;
            pc_sel_exe  <= 1'b0;
        end else begin
            out_valid <= accept;
            if (accept) begin
                a_sel_exe   <= a_sel;
                b_sel_exe   <= b_sel;
                imm_sel_exe <= imm_sel;
                alu_sel_exe <= alu_sel;
                br_comp_exe <= br_comp;
                pc_sel_exe  <= pc_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_a_exe <= data_a;
            data_b_exe <= data_b;
            pc_exe     <= pc_de;
            instr_exe  <= instruction;
        end
    end

endmodule

`default_nettype wire

/* src/credit_counter.sv */
`default_nettype none

module credit_counter (
    input  logic clk,
    input  logic rst,
    input  logic accept,
    input  logic credit_return,
    output logic in_ready
);

    import exe_ctl_pkg::*;

    logic [CREDIT_W-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= CREDIT_W'(CREDITS);
        end else begin
            case ({accept, credit_return})
                2'b10: begin
                    count <= count - 1'b1;
                end
                2'b01: begin
                    count <= count + 1'b1;
                end
                // Both or neither leave the count alone
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // Any free slot downstream lets an item in
    assign in_ready = (count != '0);

endmodule

`default_nettype wire

/* src/branch_resolve.sv */
`default_nettype none

module branch_resolve (
    input  logic [2:0]                  funct3,
    input  logic [rv_isa_pkg::XLEN-1:0] data_a,
    input  logic [rv_isa_pkg::XLEN-1:0] data_b,
    output logic                        taken
);

    import rv_isa_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (data_a == data_b);
    assign lt_s = ($signed(data_a) < $signed(data_b));
    assign lt_u = (data_a < data_b);

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = lt_s;
            F3_BGE:  taken = !lt_s;
            F3_BLTU: taken = lt_u;
            F3_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/ctl_decoder.sv */
`default_nettype none

module ctl_decoder (
    input  rv_isa_pkg::rv_instr_u instruction,
    output logic                  a_sel,
    output logic                  b_sel,
    output exe_ctl_pkg::imm_sel_e imm_sel,
    output exe_ctl_pkg::alu_op_e  alu_sel,
    output logic                  br_comp,
    output exe_ctl_pkg::pc_rule_e pc_rule
);

    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    logic op_alt;
    logic imm_alt;

    // Shared ALU mapping for OP and OP-IMM
    function automatic alu_op_e alu_from_f3(
        input logic [2:0] f3,
        input logic       alt_add,
        input logic       alt_shift
    );
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt_add ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt_shift ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // Register form keeps funct7; immediate shifts carry it in imm12[11:5]
    assign op_alt  = (instruction.r.funct7 == F7_ALT);
    assign imm_alt = (instruction.i.imm12[11:5] == F7_ALT);

    always_comb begin
        a_sel   = 1'b0;
        b_sel   = 1'b0;
        imm_sel = IMM_R;
        alu_sel = ALU_AND;
        br_comp = 1'b0;
        pc_rule = PC_SEQ;

        case (instruction.r.opcode)
            OPC_LUI: begin
                b_sel   = 1'b1;
                imm_sel = IMM_U;
                alu_sel = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = IMM_U;
                alu_sel = ALU_ADD;
            end
            OPC_JAL: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = IMM_J;
                alu_sel = ALU_ADD;
                pc_rule = PC_JUMP;
            end
            OPC_JALR: begin
                b_sel   = 1'b1;
                imm_sel = IMM_I;
                alu_sel = ALU_ADD;
                pc_rule = PC_JUMP;
            end
            OPC_BRANCH: begin
                // Target is computed by the ALU, the compare decides
                imm_sel = IMM_B;
                alu_sel = ALU_ADD;
                br_comp = 1'b1;
                pc_rule = PC_COND;
            end
            OPC_LOAD: begin
                b_sel   = 1'b1;
                imm_sel = IMM_I;
                alu_sel = ALU_ADD;
            end
            OPC_STORE: begin
                b_sel   = 1'b1;
                imm_sel = IMM_S;
                alu_sel = ALU_ADD;
            end
            OPC_OP_IMM: begin
                b_sel   = 1'b1;
                imm_sel = IMM_I;
                alu_sel = alu_from_f3(instruction.i.funct3, 1'b0, imm_alt);
            end
            OPC_OP: begin
                imm_sel = IMM_R;
                alu_sel = alu_from_f3(instruction.r.funct3, op_alt, op_alt);
            end
            // FENCE, SYSTEM and unknown opcodes stay all zero
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/exe_ctl_pkg.sv */
`default_nettype none

package exe_ctl_pkg;

    typedef enum logic [3:0] {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_XOR    = 4'd2,
        ALU_ADD    = 4'd3,
        ALU_SUB    = 4'd4,
        ALU_PASS_B = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd10,
        ALU_SLTU   = 4'd11,
        ALU_SLT    = 4'd12
    } alu_op_e;

    // Immediate format seen by the execute stage
    typedef enum logic [3:0] {
        IMM_R = 4'd0,
        IMM_I = 4'd1,
        IMM_S = 4'd2,
        IMM_B = 4'd3,
        IMM_U = 4'd4,
        IMM_J = 4'd5
    } imm_sel_e;

    // How the next PC is chosen
    typedef enum logic [1:0] {
        PC_SEQ  = 2'd0,
        PC_JUMP = 2'd1,
        PC_COND = 2'd2
    } pc_rule_e;

    // Downstream slots
    localparam int CREDITS  = 4;
    localparam int CREDIT_W = $clog2(CREDITS + 1);

endpackage

`default_nettype wire

/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the kept instruction groups
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Branch compare kinds
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU groups, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Marks SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } rv_instr_u;

endpackage

`default_nettype wire
